/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_mips_core
LINT_TOP   ?= mips_core
FLIST      ?= flist.f
BUILD      ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := Simulation PASSED
FAIL_MSG   := Simulation FAILED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run ended without a verdict"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD) $(LOG)

/* flist.f */
+incdir+hdl
hdl/mips_isa_pkg.sv
hdl/mips_ctrl_pkg.sv
hdl/mips_decoder.sv
hdl/mips_control_fsm.sv
hdl/mips_regfile.sv
hdl/mips_datapath.sv
hdl/mips_core.sv
test/mips_core_asserts.sv
test/tb_mips_core.sv

/* hdl/mips_control_fsm.sv */
`timescale 1ns/100ps

module mips_control_fsm
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  decode_t dec,
    input  logic    ack,
    output ctrl_t   ctrl,
    output logic    cyc,
    output logic    stb,
    output logic    we
);

    ctrl_state_e state;
    ctrl_state_e next_state;
    ctrl_t       ctrl_d;
    ctrl_t       ctrl_q;
    logic        req_d;
    logic        req_q;

    // Memory states hold until the slave acknowledges
    always_comb
    begin
        next_state = state;
        case (state)
            st_idle:        next_state = st_fetch;
            st_fetch:       if (ack) next_state = st_decode;
            st_decode:
            begin
                case (dec.cls)
                    cls_alu:    next_state = st_execute;
                    cls_mem:    next_state = st_mem_addr;
                    cls_branch: next_state = st_branch_addr;
                    cls_jump:   next_state = st_jump;
                    // Invalid opcode has no effect
                    default:    next_state = st_fetch;
                endcase
            end
            st_execute:     next_state = st_write_back;
            st_write_back:  next_state = st_fetch;
            st_mem_addr:    next_state = dec.is_load ? st_load : st_store;
            st_store:       if (ack) next_state = st_mem_done;
            st_load:        if (ack) next_state = st_mem_done;
            st_mem_done:    next_state = st_fetch;
            st_branch_addr: next_state = st_branch_cmp;
            st_branch_cmp:  next_state = st_fetch;
            st_jump:        next_state = st_update_pc;
            st_update_pc:   next_state = st_fetch;
            default:        next_state = st_idle;
        endcase
    end

    // Control table indexed by the state being entered
    always_comb
    begin
        ctrl_d = '0;
        req_d  = 1'b0;
        case (next_state)
            st_fetch:
            begin
                // IR load and PC + 4 in the ack cycle
                req_d            = 1'b1;
                ctrl_d.ir_write  = 1'b1;
                ctrl_d.pc_write  = 1'b1;
                ctrl_d.alu_src_b = src_b_step;
                ctrl_d.alu_op    = alu_add;
            end
            st_decode:
                ctrl_d.rdx_en = 1'b1;
            st_execute, st_mem_addr:
            begin
                // A op B or A + immediate into ALU-out
                ctrl_d.alu_src_a  = 1'b1;
                ctrl_d.alu_src_b  = dec.alu_src_b;
                ctrl_d.alu_op     = dec.alu_op;
                ctrl_d.zero_ext   = dec.zero_ext;
                ctrl_d.alu_out_en = 1'b1;
            end
            st_write_back:
            begin
                ctrl_d.reg_write  = 1'b1;
                ctrl_d.reg_dst_rd = dec.reg_dst_rd;
            end
            st_store:
            begin
                req_d         = 1'b1;
                ctrl_d.iord   = 1'b1;
                ctrl_d.mem_we = 1'b1;
            end
            st_load:
            begin
                // Register written straight from the bus at ack
                req_d             = 1'b1;
                ctrl_d.iord       = 1'b1;
                ctrl_d.data_load  = 1'b1;
                ctrl_d.mem_to_reg = 1'b1;
                ctrl_d.reg_write  = 1'b1;
                ctrl_d.reg_dst_rd = dec.reg_dst_rd;
            end
            st_mem_done:
            begin
                // Second write from the load data register
                ctrl_d.mem_to_reg = 1'b1;
                ctrl_d.reg_write  = dec.is_load;
                ctrl_d.reg_dst_rd = dec.reg_dst_rd;
            end
            st_branch_addr:
            begin
                // Target is PC + 4 + offset * 4
                ctrl_d.alu_src_b  = src_b_imm_sl2;
                ctrl_d.alu_op     = alu_add;
                ctrl_d.alu_out_en = 1'b1;
            end
            st_branch_cmp:
            begin
                ctrl_d.alu_src_a      = 1'b1;
                ctrl_d.alu_src_b      = dec.alu_src_b;
                ctrl_d.alu_op         = dec.alu_op;
                ctrl_d.pc_src_alu_out = 1'b1;
                ctrl_d.branch_eq      = ~dec.branch_ne;
                ctrl_d.branch_ne      = dec.branch_ne;
            end
            st_jump:
                ctrl_d.pc_src_alu_out = 1'b1;
            st_update_pc:
            begin
                // pc_src_alu_out with A unselected picks the jump target
                ctrl_d.pc_src_alu_out = 1'b1;
                ctrl_d.pc_write       = 1'b1;
            end
            default:
                ctrl_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state  <= st_idle;
            ctrl_q <= '0;
            req_q  <= 1'b0;
        end
        else
        begin
            state  <= next_state;
            ctrl_q <= ctrl_d;
            req_q  <= req_d;
        end
    end

    // Side effects of a bus state wait for ack
    always_comb
    begin
        ctrl = ctrl_q;
        if (req_q && !ack)
        begin
            ctrl.ir_write  = 1'b0;
            ctrl.data_load = 1'b0;
            ctrl.pc_write  = 1'b0;
            ctrl.reg_write = 1'b0;
        end
    end

    assign cyc = req_q;
    assign stb = req_q;
    assign we  = ctrl_q.mem_we;

endmodule

/* hdl/mips_core.sv */
`timescale 1ns/100ps
`include "mips_macros.svh"

module mips_core
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    output wb_m2s_t wb_out,
    input  wb_s2m_t wb_in
);

    decode_t               dec;
    ctrl_t                 ctrl;
    opcode_e               opcode;
    funct_e                funct;
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`MIPS_XLEN-1:0] adr;
    logic [`MIPS_XLEN-1:0] wdata;

    mips_decoder u_decoder
    (
        .opcode (opcode),
        .funct  (funct),
        .dec    (dec)
    );

    mips_control_fsm u_ctrl
    (
        .clk   (clk),
        .reset (reset),
        .dec   (dec),
        .ack   (wb_in.ack),
        .ctrl  (ctrl),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we)
    );

    mips_datapath u_datapath
    (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (ctrl),
        .rdata  (wb_in.dat),
        .opcode (opcode),
        .funct  (funct),
        .adr    (adr),
        .wdata  (wdata)
    );

    // Request from the FSM, address and data from the datapath
    assign wb_out.cyc = cyc;
    assign wb_out.stb = stb;
    assign wb_out.we  = we;
    assign wb_out.adr = adr;
    assign wb_out.dat = wdata;

endmodule

/* hdl/mips_ctrl_pkg.sv */
`include "mips_macros.svh"

package mips_ctrl_pkg;

    import mips_isa_pkg::*;

    // Multicycle controller states
    typedef enum logic [3:0] {
        st_idle, st_fetch, st_decode, st_execute, st_write_back,
        st_mem_addr, st_store, st_load, st_mem_done,
        st_branch_addr, st_branch_cmp, st_jump, st_update_pc
    } ctrl_state_e;

    // Operand B sources
    typedef enum logic [1:0] {
        src_b_reg     = 2'd0,
        src_b_step    = 2'd1,
        src_b_imm     = 2'd2,
        src_b_imm_sl2 = 2'd3
    } alu_src_b_e;

    typedef enum logic [2:0] {
        cls_alu, cls_mem, cls_branch, cls_jump, cls_invalid
    } instr_class_e;

    // Decoder result, static for the whole instruction
    typedef struct packed {
        instr_class_e cls;
        alu_op_e      alu_op;
        alu_src_b_e   alu_src_b;
        logic         reg_dst_rd;
        logic         zero_ext;
        logic         is_load;
        logic         branch_ne;
    } decode_t;

    // Per-state control word
    typedef struct packed {
        logic       iord;
        logic       mem_we;
        logic       ir_write;
        logic       data_load;
        logic       reg_dst_rd;
        logic       mem_to_reg;
        logic       reg_write;
        logic       pc_write;
        logic       branch_eq;
        logic       branch_ne;
        logic       pc_src_alu_out;
        logic       alu_src_a;
        alu_src_b_e alu_src_b;
        alu_op_e    alu_op;
        logic       zero_ext;
        logic       rdx_en;
        logic       alu_out_en;
    } ctrl_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`MIPS_XLEN-1:0] adr;
        logic [`MIPS_XLEN-1:0] dat;
    } wb_m2s_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic                  ack;
        logic [`MIPS_XLEN-1:0] dat;
    } wb_s2m_t;

endpackage

/* hdl/mips_datapath.sv */
`timescale 1ns/100ps
`include "mips_macros.svh"

module mips_datapath
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  ctrl_t                 ctrl,
    input  logic [`MIPS_XLEN-1:0] rdata,
    output opcode_e               opcode,
    output funct_e                funct,
    output logic [`MIPS_XLEN-1:0] adr,
    output logic [`MIPS_XLEN-1:0] wdata
);

    logic [`MIPS_XLEN-1:0]   pc;
    logic [`MIPS_XLEN-1:0]   pc_d;
    logic [`MIPS_XLEN-1:0]   ir;
    logic [`MIPS_XLEN-1:0]   a_q;
    logic [`MIPS_XLEN-1:0]   b_q;
    logic [`MIPS_XLEN-1:0]   mdr;
    logic [`MIPS_XLEN-1:0]   alu_out;
    logic [`MIPS_XLEN-1:0]   alu_a;
    logic [`MIPS_XLEN-1:0]   alu_b;
    logic [`MIPS_XLEN-1:0]   alu_y;
    logic [`MIPS_XLEN-1:0]   imm_ext;
    logic [`MIPS_XLEN-1:0]   jump_target;
    logic [`MIPS_XLEN-1:0]   rd1;
    logic [`MIPS_XLEN-1:0]   rd2;
    logic [`MIPS_XLEN-1:0]   wd;
    logic [`MIPS_REG_AW-1:0] wa;
    logic                    zero;
    logic                    branch_taken;

    assign opcode = opcode_e'(ir[31:26]);
    assign funct  = funct_e'(ir[5:0]);

    // rs, rt read; rd or rt written
    assign wa = ctrl.reg_dst_rd ? ir[15:11] : ir[20:16];
    // Load bypass in the ack cycle, load register afterwards
    assign wd = ctrl.mem_to_reg ? (ctrl.data_load ? rdata : mdr) : alu_out;

    mips_regfile u_regfile
    (
        .clk   (clk),
        .reset (reset),
        .ra1   (ir[25:21]),
        .ra2   (ir[20:16]),
        .wa    (wa),
        .we    (ctrl.reg_write),
        .wd    (wd),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    assign imm_ext = ctrl.zero_ext ? {16'b0, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
    // Upper PC bits come from PC + 4
    assign jump_target = {pc[31:28], ir[25:0], 2'b00};

    assign alu_a = ctrl.alu_src_a ? a_q : pc;

    always_comb
    begin
        case (ctrl.alu_src_b)
            src_b_reg:     alu_b = b_q;
            src_b_step:    alu_b = `MIPS_XLEN'(`MIPS_PC_STEP);
            src_b_imm:     alu_b = imm_ext;
            default:       alu_b = {imm_ext[`MIPS_XLEN-3:0], 2'b00};
        endcase
    end

    always_comb
    begin
        case (ctrl.alu_op)
            alu_sub: alu_y = alu_a - alu_b;
            alu_and: alu_y = alu_a & alu_b;
            alu_or:  alu_y = alu_a | alu_b;
            alu_slt: alu_y = {{(`MIPS_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            alu_lui: alu_y = alu_b << 16;
            default: alu_y = alu_a + alu_b;
        endcase
    end

    assign zero = (alu_y == '0);
    // beq on zero, bne on nonzero
    assign branch_taken = (ctrl.branch_eq & zero) | (ctrl.branch_ne & ~zero);

    // ALU result, ALU-out for branches, jump target otherwise
    always_comb
    begin
        if (!ctrl.pc_src_alu_out)
            pc_d = alu_y;
        else if (ctrl.alu_src_a)
            pc_d = alu_out;
        else
            pc_d = jump_target;
    end

    // Instruction or data address
    assign adr   = ctrl.iord ? alu_out : pc;
    assign wdata = b_q;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            pc <= `MIPS_XLEN'(`MIPS_RESET_PC);
            ir <= '0;
        end
        else
        begin
            if (ctrl.pc_write || branch_taken)
                pc <= pc_d;
            if (ctrl.ir_write)
                ir <= rdata;
        end
    end

    // Operand and result holding registers
    always_ff @(posedge clk)
    begin
        if (ctrl.rdx_en)
        begin
            a_q <= rd1;
            b_q <= rd2;
        end
        if (ctrl.data_load)
            mdr <= rdata;
        if (ctrl.alu_out_en)
            alu_out <= alu_y;
    end

endmodule

/* hdl/mips_decoder.sv */
`timescale 1ns/100ps

module mips_decoder
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  opcode_e opcode,
    input  funct_e  funct,
    output decode_t dec
);

    always_comb
    begin
        // Unknown opcodes fall through as invalid
        dec            = '0;
        dec.cls        = cls_invalid;
        dec.alu_op     = alu_add;
        dec.alu_src_b  = src_b_imm;
        case (opcode)
            op_rtype:
            begin
                dec.cls        = cls_alu;
                dec.alu_src_b  = src_b_reg;
                // R-type writes rd
                dec.reg_dst_rd = 1'b1;
                case (funct)
                    funct_add: dec.alu_op = alu_add;
                    funct_sub: dec.alu_op = alu_sub;
                    funct_and: dec.alu_op = alu_and;
                    funct_or:  dec.alu_op = alu_or;
                    funct_slt: dec.alu_op = alu_slt;
                    default:   dec.cls    = cls_invalid;
                endcase
            end
            op_addi:
                dec.cls = cls_alu;
            op_andi:
            begin
                dec.cls      = cls_alu;
                dec.alu_op   = alu_and;
                // Logical immediates are zero extended
                dec.zero_ext = 1'b1;
            end
            op_ori:
            begin
                dec.cls      = cls_alu;
                dec.alu_op   = alu_or;
                dec.zero_ext = 1'b1;
            end
            op_lui:
            begin
                dec.cls    = cls_alu;
                dec.alu_op = alu_lui;
            end
            op_lw:
            begin
                dec.cls     = cls_mem;
                dec.is_load = 1'b1;
            end
            op_sw:
                dec.cls = cls_mem;
            op_beq, op_bne:
            begin
                // Compare by subtraction, zero flag decides
                dec.cls       = cls_branch;
                dec.alu_op    = alu_sub;
                dec.alu_src_b = src_b_reg;
                dec.branch_ne = (opcode == op_bne);
            end
            op_j:
                dec.cls = cls_jump;
            default:
                dec.cls = cls_invalid;
        endcase
    end

endmodule

/* hdl/mips_isa_pkg.sv */
package mips_isa_pkg;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addi  = 6'h08,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_lui   = 6'h0f,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        funct_add = 6'h20,
        funct_sub = 6'h22,
        funct_and = 6'h24,
        funct_or  = 6'h25,
        funct_slt = 6'h2a
    } funct_e;

    // ALU operations
    // lui shifts operand B up by 16
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_slt = 4'd4,
        alu_lui = 4'd5
    } alu_op_e;

endpackage

/* hdl/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Data path and bus address width
`define MIPS_XLEN 32

// Register file geometry
`define MIPS_REG_AW 5
`define MIPS_NUM_REGS 32

// First fetch address after reset
`define MIPS_RESET_PC 0

// Sequential PC increment, one word
`define MIPS_PC_STEP 4

`endif

/* hdl/mips_regfile.sv */
`timescale 1ns/100ps
`include "mips_macros.svh"

module mips_regfile
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`MIPS_REG_AW-1:0] ra1,
    input  logic [`MIPS_REG_AW-1:0] ra2,
    input  logic [`MIPS_REG_AW-1:0] wa,
    input  logic                    we,
    input  logic [`MIPS_XLEN-1:0]   wd,
    output logic [`MIPS_XLEN-1:0]   rd1,
    output logic [`MIPS_XLEN-1:0]   rd2
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

    // Combinational read ports
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++)
                regs[i] <= '0;
        end
        // Register 0 stays zero
        else if (we && (wa != '0))
            regs[wa] <= wd;
    end

endmodule

/* test/mips_core_asserts.sv */
`timescale 1ns/100ps

module mips_core_asserts
    import mips_ctrl_pkg::*;
(
    input logic    clk,
    input logic    reset,
    input wb_m2s_t wb_out,
    input wb_s2m_t wb_in
);

    // A strobe is only valid inside a bus cycle
    stb_in_cycle: assert property (@(posedge clk) wb_out.stb |-> wb_out.cyc)
        else $error("stb high without cyc");

    // Request frozen until the slave acknowledges
    request_stable: assert property (@(posedge clk) disable iff (!reset)
        (wb_out.stb && !wb_in.ack) |=>
            ($stable(wb_out.adr) && $stable(wb_out.we) && $stable(wb_out.dat)))
        else $error("adr, we or dat changed during a pending request");

    // Bus idle while the core is held in reset
    idle_in_reset: assert property (@(posedge clk) !reset |-> (!wb_out.cyc && !wb_out.stb))
        else $error("bus request while reset is low");

endmodule

bind mips_core mips_core_asserts u_asserts
(
    .clk    (clk),
    .reset  (reset),
    .wb_out (wb_out),
    .wb_in  (wb_in)
);

/* test/tb_mips_core.sv */
`timescale 1ns/100ps
`include "mips_macros.svh"

module tb_mips_core
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
();

    typedef logic [`MIPS_XLEN-1:0]   word_t;
    typedef logic [2*`MIPS_XLEN-1:0] entry_t;

    localparam int MEM_WORDS = 256;
    localparam int TIMEOUT   = 4000;

    logic    clk;
    logic    reset;
    wb_m2s_t wb_out;
    wb_s2m_t wb_in;

    // Memory model and its logs
    word_t  mem [MEM_WORDS];
    entry_t store_log[$];
    entry_t expect_log[$];
    entry_t golden_log[$];
    word_t  read_log[$];
    word_t  expect_reads[$];

    // Reference register file and data memory for straight-line code
    word_t  ref_regs [32];
    word_t  ref_mem [word_t];

    word_t      prog_pc;
    word_t      halt_addr;
    int         halt_hits;
    logic       random_waits;
    word_t      rng_state;
    logic       pending;
    logic [1:0] wait_cnt;
    logic [1:0] waits;
    int         errors;
    int         tests;

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    mips_core u_dut
    (
        .clk    (clk),
        .reset  (reset),
        .wb_out (wb_out),
        .wb_in  (wb_in)
    );

    function automatic word_t lcg_next(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Wishbone slave with a one-cycle ack after 0 to 3 wait states
    initial
    begin
        wb_in    <= '0;
        pending  <= 1'b0;
        wait_cnt <= 2'd0;
        rng_state = 32'hdc40;
        forever
        begin
            @(posedge clk);
            if (!reset)
            begin
                wb_in   <= '0;
                pending <= 1'b0;
            end
            else if (wb_in.ack)
                wb_in.ack <= 1'b0;
            else if (wb_out.cyc && wb_out.stb)
            begin
                if (pending)
                    waits = wait_cnt;
                else if (random_waits)
                begin
                    rng_state = lcg_next(rng_state);
                    waits     = rng_state[17:16];
                end
                else
                    waits = 2'd0;
                if (waits != 2'd0)
                begin
                    pending  <= 1'b1;
                    wait_cnt <= waits - 2'd1;
                end
                else
                begin
                    pending   <= 1'b0;
                    wb_in.ack <= 1'b1;
                    if (wb_out.we)
                    begin
                        mem[wb_out.adr[9:2]] = wb_out.dat;
                        store_log.push_back({wb_out.adr, wb_out.dat});
                    end
                    else
                    begin
                        wb_in.dat <= mem[wb_out.adr[9:2]];
                        read_log.push_back(wb_out.adr);
                        if (wb_out.adr == halt_addr)
                            halt_hits++;
                    end
                end
            end
        end
    end

    // MIPS encodings
    function automatic word_t enc_i(input opcode_e op, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_r(input funct_e f, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [4:0] rd);
        return {op_rtype, rs, rt, rd, 5'd0, f};
    endfunction

    function automatic word_t enc_j(input word_t target);
        return {op_j, target[27:2]};
    endfunction

    // Taken branch goes to PC + 4 plus the word offset
    function automatic word_t branch_target(input word_t pc, input logic [15:0] off);
        return pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input entry_t exp, input entry_t act);
        $display("** Error %s: %s expected %0h, actual %0h", name, what, exp, act);
        errors++;
    endtask

    // Hold the core in reset and fill memory with invalid opcodes
    task automatic begin_program(input logic waits_on);
        @(posedge clk);
        reset <= 1'b0;
        // The edge above may still complete a fetch of the previous program
        @(negedge clk);
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = {6'h3f, 26'(i * 4)};
        for (int r = 0; r < 32; r++)
            ref_regs[r] = '0;
        store_log.delete();
        expect_log.delete();
        read_log.delete();
        expect_reads.delete();
        ref_mem.delete();
        prog_pc      = `MIPS_RESET_PC;
        halt_addr    = '1;
        halt_hits    = 0;
        random_waits = waits_on;
    endtask

    task automatic emit_word(input word_t w);
        mem[prog_pc[9:2]] = w;
        prog_pc = prog_pc + 32'd4;
    endtask

    task automatic emit_imm(input opcode_e op, input logic [4:0] rt,
                            input logic [4:0] rs, input logic [15:0] imm);
        word_t res;
        case (op)
            op_andi: res = ref_regs[rs] & {16'h0, imm};
            op_ori:  res = ref_regs[rs] | {16'h0, imm};
            op_lui:  res = {imm, 16'h0};
            default: res = ref_regs[rs] + {{16{imm[15]}}, imm};
        endcase
        // Register 0 ignores writes
        if (rt != 5'd0)
            ref_regs[rt] = res;
        emit_word(enc_i(op, rs, rt, imm));
    endtask

    task automatic emit_rtype(input funct_e f, input logic [4:0] rd,
                              input logic [4:0] rs, input logic [4:0] rt);
        word_t a;
        word_t b;
        word_t res;
        a = ref_regs[rs];
        b = ref_regs[rt];
        case (f)
            funct_sub: res = a - b;
            funct_and: res = a & b;
            funct_or:  res = a | b;
            funct_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:   res = a + b;
        endcase
        if (rd != 5'd0)
            ref_regs[rd] = res;
        emit_word(enc_r(f, rs, rt, rd));
    endtask

    task automatic emit_sw(input logic [4:0] rt, input logic [15:0] off, input logic [4:0] base);
        word_t addr;
        addr = ref_regs[base] + {{16{off[15]}}, off};
        ref_mem[addr] = ref_regs[rt];
        expect_log.push_back({addr, ref_regs[rt]});
        emit_word(enc_i(op_sw, base, rt, off));
    endtask

    task automatic emit_lw(input logic [4:0] rt, input logic [15:0] off, input logic [4:0] base);
        word_t addr;
        addr = ref_regs[base] + {{16{off[15]}}, off};
        if (rt != 5'd0)
            ref_regs[rt] = ref_mem[addr];
        emit_word(enc_i(op_lw, base, rt, off));
    endtask

    // Jump to itself as the end-of-program marker
    task automatic emit_halt();
        halt_addr = prog_pc;
        emit_word(enc_j(prog_pc));
    endtask

    // Release reset and run until the halt loop is fetched twice
    task automatic run_program(input string name);
        int cycles;
        repeat (8) @(posedge clk);
        reset  <= 1'b1;
        cycles = 0;
        while (halt_hits < 2 && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (halt_hits < 2)
        begin
            $display("%s: timed out, the program never reached its halt loop", name);
            errors++;
        end
    endtask

    task automatic check_stores(input string name);
        if (store_log.size() != expect_log.size())
            report_mismatch(name, "store count", expect_log.size(), store_log.size());
        else
        begin
            for (int i = 0; i < store_log.size(); i++)
                if (store_log[i] !== expect_log[i])
                    report_mismatch(name, "store {adr,dat}", expect_log[i], store_log[i]);
        end
    endtask

    task automatic check_reads(input string name);
        if (read_log.size() < expect_reads.size())
            report_mismatch(name, "fetch count", expect_reads.size(), read_log.size());
        else
        begin
            for (int i = 0; i < expect_reads.size(); i++)
                if (read_log[i] !== expect_reads[i])
                    report_mismatch(name, "fetch address", expect_reads[i], read_log[i]);
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests++;
        if (errors == start_errors)
            $display("%s: passed", name);
        else
            $display("%s: failed with %0d errors", name, errors - start_errors);
    endtask

    task automatic test_reset_fetch();
        int start;
        int cycles;
        start = errors;
        begin_program(1'b0);
        emit_halt();
        // Bus stays idle for the whole reset
        repeat (7)
        begin
            @(negedge clk);
            if (wb_out.stb || wb_out.cyc)
            begin
                $display("reset_fetch: bus request raised while reset is low");
                errors++;
            end
        end
        @(posedge clk);
        reset  <= 1'b1;
        cycles = 0;
        while (!wb_out.stb && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!wb_out.stb)
        begin
            $display("reset_fetch: timed out, no bus request after reset");
            errors++;
        end
        else
        begin
            if (wb_out.adr !== `MIPS_RESET_PC)
                report_mismatch("reset_fetch", "first adr", `MIPS_RESET_PC, wb_out.adr);
            if (wb_out.we !== 1'b0)
                report_mismatch("reset_fetch", "first we", 0, wb_out.we);
        end
        finish_test("reset_fetch", start);
    endtask

    task automatic build_alu_program(input logic waits_on);
        begin_program(waits_on);
        emit_imm(op_addi, 5'd1, 5'd0, 16'h1234);
        emit_imm(op_addi, 5'd2, 5'd0, 16'hfffb);
        emit_imm(op_lui,  5'd3, 5'd0, 16'ha5a5);
        emit_imm(op_ori,  5'd3, 5'd3, 16'h8001);
        emit_imm(op_andi, 5'd4, 5'd2, 16'hff0f);
        emit_rtype(funct_add, 5'd5, 5'd1, 5'd2);
        emit_rtype(funct_sub, 5'd6, 5'd1, 5'd2);
        emit_rtype(funct_and, 5'd7, 5'd3, 5'd2);
        emit_rtype(funct_or,  5'd8, 5'd1, 5'd3);
        emit_rtype(funct_slt, 5'd9, 5'd2, 5'd1);
        emit_rtype(funct_slt, 5'd10, 5'd1, 5'd2);
        // Write to register 0 must be lost
        emit_imm(op_addi, 5'd0, 5'd1, 16'h0007);
        emit_rtype(funct_add, 5'd11, 5'd0, 5'd1);
        for (int r = 0; r < 12; r++)
            emit_sw(5'(r), 16'(16'h0200 + 4 * r), 5'd0);
        emit_halt();
    endtask

    task automatic test_alu_ops();
        int start;
        start = errors;
        build_alu_program(1'b0);
        run_program("alu_ops");
        check_stores("alu_ops");
        golden_log = store_log;
        finish_test("alu_ops", start);
    endtask

    task automatic test_load_store();
        int start;
        start = errors;
        begin_program(1'b0);
        emit_imm(op_lui, 5'd1, 5'd0, 16'hdead);
        emit_imm(op_ori, 5'd1, 5'd1, 16'hbeef);
        emit_sw(5'd1, 16'h0300, 5'd0);
        emit_lw(5'd2, 16'h0300, 5'd0);
        emit_sw(5'd2, 16'h0304, 5'd0);
        emit_halt();
        run_program("load_store");
        check_stores("load_store");
        finish_test("load_store", start);
    endtask

    task automatic test_branches();
        int start;
        start = errors;
        begin_program(1'b0);
        emit_imm(op_addi, 5'd1, 5'd0, 16'd5);
        emit_imm(op_addi, 5'd2, 5'd0, 16'd5);
        emit_imm(op_addi, 5'd3, 5'd0, 16'd7);
        // beq taken at 0x0c skips a marker
        emit_word(enc_i(op_beq, 5'd1, 5'd2, 16'd1));
        emit_word(enc_i(op_sw, 5'd0, 5'd3, 16'h03f0));
        emit_word(enc_i(op_beq, 5'd1, 5'd3, 16'd1));
        emit_sw(5'd1, 16'h0200, 5'd0);
        // bne taken at 0x1c
        emit_word(enc_i(op_bne, 5'd1, 5'd3, 16'd1));
        emit_word(enc_i(op_sw, 5'd0, 5'd3, 16'h03f4));
        emit_word(enc_i(op_bne, 5'd1, 5'd2, 16'd1));
        emit_sw(5'd2, 16'h0208, 5'd0);
        emit_halt();
        for (int a = 0; a <= 'h0c; a += 4)
            expect_reads.push_back(word_t'(a));
        expect_reads.push_back(branch_target(32'h0c, 16'd1));
        expect_reads.push_back(32'h18);
        expect_reads.push_back(32'h1c);
        expect_reads.push_back(branch_target(32'h1c, 16'd1));
        expect_reads.push_back(32'h28);
        expect_reads.push_back(32'h2c);
        run_program("branches");
        check_stores("branches");
        check_reads("branches");
        finish_test("branches", start);
    endtask

    task automatic test_jump_invalid();
        int start;
        start = errors;
        begin_program(1'b0);
        emit_imm(op_addi, 5'd1, 5'd0, 16'd9);
        emit_word(enc_j(32'h40));
        emit_word(enc_i(op_sw, 5'd0, 5'd1, 16'h0200));
        prog_pc = 32'h40;
        // Unsupported opcode with sw-like fields
        emit_word({6'h3f, 5'd0, 5'd1, 16'h0300});
        emit_sw(5'd1, 16'h0204, 5'd0);
        emit_halt();
        expect_reads.push_back(32'h00);
        expect_reads.push_back(32'h04);
        expect_reads.push_back(32'h40);
        expect_reads.push_back(32'h44);
        expect_reads.push_back(32'h48);
        run_program("jump_invalid");
        check_stores("jump_invalid");
        check_reads("jump_invalid");
        finish_test("jump_invalid", start);
    endtask

    task automatic test_random_waits();
        int start;
        start = errors;
        build_alu_program(1'b1);
        run_program("random_waits");
        check_stores("random_waits");
        // Scoreboard must match the zero-wait run
        expect_log = golden_log;
        check_stores("random_waits");
        finish_test("random_waits", start);
    endtask

    initial
    begin
        reset        = 1'b1;
        errors       = 0;
        tests        = 0;
        random_waits = 1'b0;
        halt_addr    = '1;
        halt_hits    = 0;
        test_reset_fetch();
        test_alu_ops();
        test_load_store();
        test_branches();
        test_jump_invalid();
        test_random_waits();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
